// ==== filelist.f ====
logic/brsPkg.sv
logic/brsEntry.sv
logic/brsAlloc.sv
logic/brsIssue.sv
logic/branchStation.sv
tests/branchStationChecker.sv
tests/branchStationTb.sv

// ==== logic/branchStation.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchStation (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 rdy,
    input  wire                                 aluWrEn,
    input  wire [brsPkg::tagWidth-1:0]          aluTag,
    input  wire [brsPkg::dataWidth-1:0]         aluData,
    input  wire                                 lsWrEn,
    input  wire [brsPkg::tagWidth-1:0]          lsTag,
    input  wire [brsPkg::dataWidth-1:0]         lsData,
    input  wire                                 dispEn,
    input  wire [brsPkg::dataWidth-1:0]         dispOperandA,
    input  wire [brsPkg::dataWidth-1:0]         dispOperandB,
    input  wire [brsPkg::tagWidth-1:0]          dispTagA,
    input  wire [brsPkg::tagWidth-1:0]          dispTagB,
    input  wire brsPkg::brOp                    dispOp,
    input  wire [brsPkg::dataWidth-1:0]         dispImm,
    input  wire [brsPkg::addrWidth-1:0]         dispPc,
    input  wire [brsPkg::branchMaskWidth-1:0]   dispMask,
    input  wire                                 bFreeEn,
    input  wire [brsPkg::slotWidth-1:0]         bFreeNum,
    input  wire                                 misTaken,
    output logic                                full,
    output logic                                issueEn,
    output logic [brsPkg::dataWidth-1:0]        operandA,
    output logic [brsPkg::dataWidth-1:0]        operandB,
    output logic [brsPkg::dataWidth-1:0]        imm,
    output brsPkg::brOp                         opCode,
    output logic [brsPkg::addrWidth-1:0]        pc,
    output logic [brsPkg::slotWidth-1:0]        bNum
);
    import brsPkg::*;

    logic [rsSize-1:0]                allocEn;
    logic [rsSize-1:0]                busy;
    logic [rsSize-1:0]                ready;
    logic [rsSize-1:0]                issueAck;
    logic [rsSize-1:0][dataWidth-1:0] slotOperandA;
    logic [rsSize-1:0][dataWidth-1:0] slotOperandB;
    brOp  [rsSize-1:0]                slotOp;
    logic [rsSize-1:0][dataWidth-1:0] slotImm;
    logic [rsSize-1:0][addrWidth-1:0] slotPc;

    brsAlloc alloc_i (
        .clk     (clk),
        .rst     (rst),
        .rdy     (rdy),
        .flush   (misTaken),
        .dispEn  (dispEn),
        .busy    (busy),
        .allocEn (allocEn),
        .full    (full)
    );

    // every slot sees the same dispatch fields, only allocEn selects one
    for (genvar i = 0; i < rsSize; i++) begin : slot
        brsEntry entry_i (
            .clk           (clk),
            .rst           (rst),
            .rdy           (rdy),
            .flush         (misTaken),
            .aluWrEn       (aluWrEn),
            .aluTag        (aluTag),
            .aluData       (aluData),
            .lsWrEn        (lsWrEn),
            .lsTag         (lsTag),
            .lsData        (lsData),
            .allocEn       (allocEn[i]),
            .allocOperandA (dispOperandA),
            .allocOperandB (dispOperandB),
            .allocTagA     (dispTagA),
            .allocTagB     (dispTagB),
            .allocOp       (dispOp),
            .allocImm      (dispImm),
            .allocPc       (dispPc),
            .allocMask     (dispMask),
            .bFreeEn       (bFreeEn),
            .bFreeNum      (bFreeNum),
            .issueAck      (issueAck[i]),
            .busy          (busy[i]),
            .ready         (ready[i]),
            .issueOperandA (slotOperandA[i]),
            .issueOperandB (slotOperandB[i]),
            .issueOp       (slotOp[i]),
            .issueImm      (slotImm[i]),
            .issuePc       (slotPc[i])
        );
    end

    brsIssue issue_i (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .flush        (misTaken),
        .ready        (ready),
        .busy         (busy),
        .slotOperandA (slotOperandA),
        .slotOperandB (slotOperandB),
        .slotOp       (slotOp),
        .slotImm      (slotImm),
        .slotPc       (slotPc),
        .issueAck     (issueAck),
        .issueEn      (issueEn),
        .operandA     (operandA),
        .operandB     (operandB),
        .imm          (imm),
        .opCode       (opCode),
        .pc           (pc),
        .bNum         (bNum)
    );

endmodule

`default_nettype wire

// ==== logic/brsAlloc.sv ====
`timescale 1ns/1ps
`default_nettype none

module brsAlloc (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         rdy,
    input  wire                         flush,
    input  wire                         dispEn,
    input  wire [brsPkg::rsSize-1:0]    busy,
    output logic [brsPkg::rsSize-1:0]   allocEn,
    output logic                        full
);
    import brsPkg::*;

    // tail points at the next slot to fill
    logic [slotWidth-1:0] tail;

    // slots drain in order, so the tail slot is the last to empty
    assign full = busy[tail];

    // a flush in the same cycle wins over the dispatch
    always_comb begin
        allocEn = '0;
        if (dispEn && !flush) begin
            allocEn[tail] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tail <= '0;
        end else if (rdy) begin
            if (flush) begin
                tail <= '0;
            end else if (dispEn) begin
                tail <= (tail == slotWidth'(rsSize - 1)) ? '0 : tail + 1'b1;
            end
        end
    end

    // the dispatcher has to respect full
    noDispatchWhenFull: assert property (
        @(posedge clk) disable iff (rst) (rdy && dispEn) |-> !full
    ) else $error("brsAlloc: dispatch while the station is full");

endmodule

`default_nettype wire

// ==== logic/brsEntry.sv ====
`timescale 1ns/1ps
`default_nettype none

module brsEntry (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 rdy,
    input  wire                                 flush,
    input  wire                                 aluWrEn,
    input  wire [brsPkg::tagWidth-1:0]          aluTag,
    input  wire [brsPkg::dataWidth-1:0]         aluData,
    input  wire                                 lsWrEn,
    input  wire [brsPkg::tagWidth-1:0]          lsTag,
    input  wire [brsPkg::dataWidth-1:0]         lsData,
    input  wire                                 allocEn,
    input  wire [brsPkg::dataWidth-1:0]         allocOperandA,
    input  wire [brsPkg::dataWidth-1:0]         allocOperandB,
    input  wire [brsPkg::tagWidth-1:0]          allocTagA,
    input  wire [brsPkg::tagWidth-1:0]          allocTagB,
    input  wire brsPkg::brOp                    allocOp,
    input  wire [brsPkg::dataWidth-1:0]         allocImm,
    input  wire [brsPkg::addrWidth-1:0]         allocPc,
    input  wire [brsPkg::branchMaskWidth-1:0]   allocMask,
    input  wire                                 bFreeEn,
    input  wire [brsPkg::slotWidth-1:0]         bFreeNum,
    input  wire                                 issueAck,
    output logic                                busy,
    output logic                                ready,
    output logic [brsPkg::dataWidth-1:0]        issueOperandA,
    output logic [brsPkg::dataWidth-1:0]        issueOperandB,
    output brsPkg::brOp                         issueOp,
    output logic [brsPkg::dataWidth-1:0]        issueImm,
    output logic [brsPkg::addrWidth-1:0]        issuePc
);
    import brsPkg::*;

    logic [tagWidth-1:0]        tagA;
    logic [tagWidth-1:0]        tagB;
    logic [dataWidth-1:0]       dataA;
    logic [dataWidth-1:0]       dataB;
    logic [branchMaskWidth-1:0] mask;
    brOp                        heldOp;
    logic [dataWidth-1:0]       heldImm;
    logic [addrWidth-1:0]       heldPc;

    logic [tagWidth-1:0]        nextTagA;
    logic [tagWidth-1:0]        nextTagB;
    logic [dataWidth-1:0]       nextDataA;
    logic [dataWidth-1:0]       nextDataB;
    logic [branchMaskWidth-1:0] nextMask;

    // a tag seen on either bus this cycle becomes free
    function automatic logic [tagWidth-1:0] wakeTag(input logic [tagWidth-1:0] tag);
        logic hit;
        hit = (aluWrEn && aluTag == tag) || (lsWrEn && lsTag == tag);
        return hit ? tagFree : tag;
    endfunction

    function automatic logic [dataWidth-1:0] wakeData(input logic [tagWidth-1:0] tag,
                                                      input logic [dataWidth-1:0] data);
        logic [dataWidth-1:0] result;
        result = data;
        if (aluWrEn && aluTag == tag) begin
            result = aluData;
        end else if (lsWrEn && lsTag == tag) begin
            result = lsData;
        end
        return result;
    endfunction

    function automatic logic [branchMaskWidth-1:0] clearMask(
        input logic [branchMaskWidth-1:0] m
    );
        return bFreeEn ? (m & ~(branchMaskWidth'(1) << bFreeNum)) : m;
    endfunction

    // the stored fields as they will be after this edge
    always_comb begin
        nextTagA  = wakeTag(tagA);
        nextTagB  = wakeTag(tagB);
        nextDataA = wakeData(tagA, dataA);
        nextDataB = wakeData(tagB, dataB);
        nextMask  = clearMask(mask);
    end

    assign ready = busy && nextTagA == tagFree && nextTagB == tagFree && nextMask == '0;

    // operands bypass a broadcast that lands in the issue cycle
    assign issueOperandA = nextDataA;
    assign issueOperandB = nextDataB;
    assign issueOp       = heldOp;
    assign issueImm      = heldImm;
    assign issuePc       = heldPc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (rdy) begin
            if (flush || issueAck) begin
                busy <= 1'b0;
            end else if (allocEn) begin
                busy <= 1'b1;
            end
        end
    end

    // incoming fields are snooped too, so a result arriving with the dispatch is kept
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (allocEn) begin
                tagA    <= wakeTag(allocTagA);
                tagB    <= wakeTag(allocTagB);
                dataA   <= wakeData(allocTagA, allocOperandA);
                dataB   <= wakeData(allocTagB, allocOperandB);
                mask    <= clearMask(allocMask);
                heldOp  <= allocOp;
                heldImm <= allocImm;
                heldPc  <= allocPc;
            end else begin
                tagA  <= nextTagA;
                tagB  <= nextTagB;
                dataA <= nextDataA;
                dataB <= nextDataB;
                mask  <= nextMask;
            end
        end
    end

    // the allocator must only pick a slot that has drained
    allocIntoEmpty: assert property (
        @(posedge clk) disable iff (rst) (rdy && allocEn && !flush) |-> !busy
    ) else $error("brsEntry: allocation into a busy slot");

endmodule

`default_nettype wire

// ==== logic/brsIssue.sv ====
`timescale 1ns/1ps
`default_nettype none

module brsIssue (
    input  wire                                             clk,
    input  wire                                             rst,
    input  wire                                             rdy,
    input  wire                                             flush,
    input  wire [brsPkg::rsSize-1:0]                        ready,
    input  wire [brsPkg::rsSize-1:0]                        busy,
    input  wire [brsPkg::rsSize-1:0][brsPkg::dataWidth-1:0] slotOperandA,
    input  wire [brsPkg::rsSize-1:0][brsPkg::dataWidth-1:0] slotOperandB,
    input  wire brsPkg::brOp [brsPkg::rsSize-1:0]           slotOp,
    input  wire [brsPkg::rsSize-1:0][brsPkg::dataWidth-1:0] slotImm,
    input  wire [brsPkg::rsSize-1:0][brsPkg::addrWidth-1:0] slotPc,
    output logic [brsPkg::rsSize-1:0]                       issueAck,
    output logic                                            issueEn,
    output logic [brsPkg::dataWidth-1:0]                    operandA,
    output logic [brsPkg::dataWidth-1:0]                    operandB,
    output logic [brsPkg::dataWidth-1:0]                    imm,
    output brsPkg::brOp                                     opCode,
    output logic [brsPkg::addrWidth-1:0]                    pc,
    output logic [brsPkg::slotWidth-1:0]                    bNum
);
    import brsPkg::*;

    // head is the oldest slot still waiting
    logic [slotWidth-1:0] head;
    logic                 fire;

    // only the head may leave, which keeps issue in program order
    assign fire = rdy && !flush && ready[head];

    always_comb begin
        issueAck = '0;
        if (fire) begin
            issueAck[head] = 1'b1;
        end
    end

    // issueEn is a pulse, so it drops back to idle even while frozen
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head    <= '0;
            issueEn <= 1'b0;
            opCode  <= nop;
            bNum    <= '0;
        end else begin
            issueEn <= fire;
            if (fire) begin
                opCode <= slotOp[head];
                bNum   <= head;
            end else begin
                opCode <= nop;
            end

            if (rdy && flush) begin
                head <= '0;
            end else if (fire) begin
                head <= (head == slotWidth'(rsSize - 1)) ? '0 : head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            operandA <= slotOperandA[head];
            operandB <= slotOperandB[head];
            imm      <= slotImm[head];
            pc       <= slotPc[head];
        end
    end

    // a slot that reports ready must also hold an instruction
    ackOnlyBusy: assert property (
        @(posedge clk) disable iff (rst) (issueAck & ~busy) == '0
    ) else $error("brsIssue: issue acknowledged to an empty slot");

endmodule

`default_nettype wire

// ==== logic/brsPkg.sv ====
`default_nettype none

package brsPkg;

    // operand, immediate and PC widths
    localparam int dataWidth = 32;
    localparam int addrWidth = 32;

    // producer tags coming from rename
    localparam int tagWidth = 4;

    // a tag of zero means the value is already in the slot
    localparam logic [tagWidth-1:0] tagFree = '0;

    // station geometry
    localparam int rsSize = 4;
    localparam int slotWidth = 2;

    // one mask bit per branch number that may still be unresolved
    localparam int branchMaskWidth = 4;

    localparam int opWidth = 4;

    // nop is what the issue port shows while nothing leaves
    typedef enum logic [opWidth-1:0] {
        nop  = 4'd0,
        beq  = 4'd1,
        bne  = 4'd2,
        blt  = 4'd3,
        bge  = 4'd4,
        bltu = 4'd5,
        bgeu = 4'd6,
        jal  = 4'd7,
        jalr = 4'd8
    } brOp;

endpackage

`default_nettype wire

// ==== tests/branchStationChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchStationChecker (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 rdy,
    input  wire                                 aluWrEn,
    input  wire [brsPkg::tagWidth-1:0]          aluTag,
    input  wire [brsPkg::dataWidth-1:0]         aluData,
    input  wire                                 lsWrEn,
    input  wire [brsPkg::tagWidth-1:0]          lsTag,
    input  wire [brsPkg::dataWidth-1:0]         lsData,
    input  wire                                 dispEn,
    input  wire [brsPkg::dataWidth-1:0]         dispOperandA,
    input  wire [brsPkg::dataWidth-1:0]         dispOperandB,
    input  wire [brsPkg::tagWidth-1:0]          dispTagA,
    input  wire [brsPkg::tagWidth-1:0]          dispTagB,
    input  wire brsPkg::brOp                    dispOp,
    input  wire [brsPkg::dataWidth-1:0]         dispImm,
    input  wire [brsPkg::addrWidth-1:0]         dispPc,
    input  wire [brsPkg::branchMaskWidth-1:0]   dispMask,
    input  wire                                 bFreeEn,
    input  wire [brsPkg::slotWidth-1:0]         bFreeNum,
    input  wire                                 misTaken,
    input  wire                                 full,
    input  wire                                 issueEn,
    input  wire [brsPkg::dataWidth-1:0]         operandA,
    input  wire [brsPkg::dataWidth-1:0]         operandB,
    input  wire [brsPkg::dataWidth-1:0]         imm,
    input  wire brsPkg::brOp                    opCode,
    input  wire [brsPkg::addrWidth-1:0]         pc,
    input  wire [brsPkg::slotWidth-1:0]         bNum
);
    import brsPkg::*;

    string testName = "reset";
    int    expectIssues = 0;
    int    issues = 0;
    int    errors = 0;
    int    outstanding = 0;
    int    waiting = 0;
    int    passedTests = 0;
    int    failedTests = 0;
    int    totalErrors = 0;
    logic  lastRdy = 1'b0;
    logic  dueIssue = 1'b0;
    logic  armed = 1'b0;

    // expected contents, kept as a circular queue in program order
    logic [slotWidth-1:0]       head = '0;
    logic [slotWidth-1:0]       tail = '0;
    brOp                        pendOp [rsSize];
    logic [tagWidth-1:0]        pendTagA [rsSize];
    logic [tagWidth-1:0]        pendTagB [rsSize];
    logic [dataWidth-1:0]       pendDataA [rsSize];
    logic [dataWidth-1:0]       pendDataB [rsSize];
    logic [branchMaskWidth-1:0] pendMask [rsSize];
    logic [dataWidth-1:0]       pendImm [rsSize];
    logic [addrWidth-1:0]       pendPc [rsSize];

    task automatic beginTest(input string name, input int expected);
        testName     = name;
        expectIssues = expected;
        issues       = 0;
    endtask

    task automatic expectEqual(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s: %s expected %h actual %h", testName, field, expected, actual);
            errors++;
        end
    endtask

    task automatic endTest();
        if (outstanding != 0) begin
            $display("%s: %0d instructions were never issued", testName, outstanding);
            errors++;
        end
        expectEqual("issue count", expectIssues, issues);
        if (errors == 0) begin
            passedTests++;
            $display("test %s passed with %0d issues", testName, issues);
        end else begin
            failedTests++;
            $display("test %s failed with %0d errors", testName, errors);
        end
        totalErrors += errors;
        errors = 0;
    endtask

    task automatic printTotals();
        $display("%0d passed, %0d failed, %0d errors in total",
                 passedTests, failedTests, totalErrors);
    endtask

    task automatic checkIssue();
        if (!lastRdy) begin
            $display("%s: an instruction issued while rdy was low", testName);
            errors++;
        end
        if (outstanding == 0) begin
            $display("%s: an instruction issued with nothing outstanding", testName);
            errors++;
        end else begin
            expectEqual("opCode", pendOp[head], opCode);
            expectEqual("operandA", pendDataA[head], operandA);
            expectEqual("operandB", pendDataB[head], operandB);
            expectEqual("imm", pendImm[head], imm);
            expectEqual("pc", pendPc[head], pc);
            expectEqual("bNum", head, bNum);
            if (pendTagA[head] != tagFree || pendTagB[head] != tagFree || pendMask[head] != '0) begin
                $display("%s: slot %0d issued before its operands and mask were clear",
                         testName, head);
                errors++;
            end
            head = head + 1'b1;
            outstanding--;
            issues++;
        end
    endtask

    // inputs were driven half a cycle earlier and are stable here
    always @(posedge clk) begin
        if (rst) begin
            head        = '0;
            tail        = '0;
            outstanding = 0;
            lastRdy     = 1'b0;
            dueIssue    = 1'b0;
            armed       = 1'b0;
        end else begin
            armed   = 1'b1;
            lastRdy = rdy;
            waiting = outstanding;
            if (rdy && misTaken) begin
                head        = '0;
                tail        = '0;
                outstanding = 0;
            end else if (rdy) begin
                if (dispEn) begin
                    pendOp[tail]    = dispOp;
                    pendTagA[tail]  = dispTagA;
                    pendTagB[tail]  = dispTagB;
                    pendDataA[tail] = dispOperandA;
                    pendDataB[tail] = dispOperandB;
                    pendMask[tail]  = dispMask;
                    pendImm[tail]   = dispImm;
                    pendPc[tail]    = dispPc;
                    tail = tail + 1'b1;
                    outstanding++;
                end
                // a result on either bus fills every operand waiting on its tag
                for (int i = 0; i < rsSize; i++) begin
                    if (aluWrEn && aluTag == pendTagA[i]) begin
                        pendDataA[i] = aluData;
                        pendTagA[i]  = tagFree;
                    end else if (lsWrEn && lsTag == pendTagA[i]) begin
                        pendDataA[i] = lsData;
                        pendTagA[i]  = tagFree;
                    end
                    if (aluWrEn && aluTag == pendTagB[i]) begin
                        pendDataB[i] = aluData;
                        pendTagB[i]  = tagFree;
                    end else if (lsWrEn && lsTag == pendTagB[i]) begin
                        pendDataB[i] = lsData;
                        pendTagB[i]  = tagFree;
                    end
                    if (bFreeEn) begin
                        pendMask[i][bFreeNum] = 1'b0;
                    end
                end
            end
            // the oldest stored instruction leaves at this edge once it was ready before it
            dueIssue = rdy && !misTaken && waiting != 0 && pendTagA[head] == tagFree
                       && pendTagB[head] == tagFree && pendMask[head] == '0;
        end
    end

    // registered outputs settle after the rising edge
    always @(negedge clk) begin
        if (armed) begin
            expectEqual("issueEn", dueIssue, issueEn);
            if (issueEn) begin
                checkIssue();
            end else begin
                expectEqual("idle opCode", nop, opCode);
            end
            expectEqual("full", outstanding == rsSize, full);
        end
    end

endmodule

`default_nettype wire

// ==== tests/branchStationTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchStationTb;
    import brsPkg::*;

    localparam int numTests = 6;
    localparam int drainLimit = 20;

    // one clock cycle of stimulus, a tag of zero means no broadcast
    typedef struct packed {
        logic [2:0]                 test;
        brOp                        op;
        logic [tagWidth-1:0]        tagA;
        logic [tagWidth-1:0]        tagB;
        logic [branchMaskWidth-1:0] mask;
        logic [tagWidth-1:0]        aluTag;
        logic [tagWidth-1:0]        lsTag;
        logic                       freeEn;
        logic [slotWidth-1:0]       freeNum;
        logic                       flush;
        logic                       frz;
    } stimStep;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       rdy;
    logic                       aluWrEn;
    logic [tagWidth-1:0]        aluTag;
    logic [dataWidth-1:0]       aluData;
    logic                       lsWrEn;
    logic [tagWidth-1:0]        lsTag;
    logic [dataWidth-1:0]       lsData;
    logic                       dispEn;
    logic [dataWidth-1:0]       dispOperandA;
    logic [dataWidth-1:0]       dispOperandB;
    logic [tagWidth-1:0]        dispTagA;
    logic [tagWidth-1:0]        dispTagB;
    brOp                        dispOp;
    logic [dataWidth-1:0]       dispImm;
    logic [addrWidth-1:0]       dispPc;
    logic [branchMaskWidth-1:0] dispMask;
    logic                       bFreeEn;
    logic [slotWidth-1:0]       bFreeNum;
    logic                       misTaken;
    logic                       full;
    logic                       issueEn;
    logic [dataWidth-1:0]       operandA;
    logic [dataWidth-1:0]       operandB;
    logic [dataWidth-1:0]       imm;
    brOp                        opCode;
    logic [addrWidth-1:0]       pc;
    logic [slotWidth-1:0]       bNum;

    stimStep     steps[$];
    string       testName [numTests];
    int          expectIssues [numTests];
    logic [31:0] lfsr = 32'h9e1d2d5f;

    branchStation dut_i (.*);

    branchStationChecker check_i (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] stepLfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = stepLfsr(lfsr);
        end
        return v;
    endfunction

    // free is a branch number, or -1 when nothing is freed
    function automatic stimStep makeStep(input int test, input brOp op, input int tagA,
                                         input int tagB, input int mask, input int aluTag,
                                         input int lsTag, input int free, input bit flush,
                                         input bit frz);
        stimStep s;
        s.test    = 3'(test);
        s.op      = op;
        s.tagA    = tagWidth'(tagA);
        s.tagB    = tagWidth'(tagB);
        s.mask    = branchMaskWidth'(mask);
        s.aluTag  = tagWidth'(aluTag);
        s.lsTag   = tagWidth'(lsTag);
        s.freeEn  = free >= 0;
        s.freeNum = slotWidth'(free);
        s.flush   = flush;
        s.frz     = frz;
        return s;
    endfunction

    task automatic loadTable();
        testName[0] = "readyAtDispatch";
        expectIssues[0] = 2;
        steps.push_back(makeStep(0, beq, 0, 0, 4'b0000, 0, 0, -1, 0, 0));
        steps.push_back(makeStep(0, nop, 0, 0, 4'b0000, 0, 0, -1, 0, 0));
        steps.push_back(makeStep(0, jal, 0, 0, 4'b0000, 0, 0, -1, 0, 0));
        testName[1] = "wakeup";
        expectIssues[1] = 3;
        steps.push_back(makeStep(1, bne, 3, 5, 4'b0000, 0, 0, -1, 0, 0));
        steps.push_back(makeStep(1, nop, 0, 0, 4'b0000, 0, 0, -1, 0, 0));
        steps.push_back(makeStep(1, nop, 0, 0, 4'b0000, 3, 0, -1, 0, 0));
        steps.push_back(makeStep(1, nop, 0, 0, 4'b0000, 0, 0, -1, 0, 0));
        steps.push_back(makeStep(1, nop, 0, 0, 4'b0000, 0, 5, -1, 0, 0));
        // result arrives together with the dispatch
        steps.push_back(makeStep(1, blt, 6, 7, 4'b0000, 6, 0, -1, 0, 0));
        steps.push_back(makeStep(1, nop, 0, 0, 4'b0000, 0, 7, -1, 0, 0));
        steps.push_back(makeStep(1, bge, 8, 9, 4'b0000, 0, 0, -1, 0, 0));
        steps.push_back(makeStep(1, nop, 0, 0, 4'b0000, 8, 9, -1, 0, 0));
        testName[2] = "inOrder";
        expectIssues[2] = 4;
        steps.push_back(makeStep(2, bltu, 2, 0, 4'b0000, 0, 0, -1, 0, 0));
        steps.push_back(makeStep(2, bgeu, 0, 0, 4'b0000, 0, 0, -1, 0, 0));
        steps.push_back(makeStep(2, jalr, 0, 0, 4'b0000, 0, 0, -1, 0, 0));
        steps.push_back(makeStep(2, nop, 0, 0, 4'b0000, 0, 0, -1, 0, 0));
        steps.push_back(makeStep(2, nop, 0, 0, 4'b0000, 2, 0, -1, 0, 0));
        steps.push_back(makeStep(2, beq, 0, 0, 4'b0000, 0, 0, -1, 0, 0));
        testName[3] = "branchMask";
        expectIssues[3] = 2;
        steps.push_back(makeStep(3, beq, 0, 0, 4'b0101, 0, 0, -1, 0, 0));
        steps.push_back(makeStep(3, nop, 0, 0, 4'b0000, 0, 0, -1, 0, 0));
        steps.push_back(makeStep(3, nop, 0, 0, 4'b0000, 0, 0, 0, 0, 0));
        steps.push_back(makeStep(3, nop, 0, 0, 4'b0000, 0, 0, -1, 0, 0));
        steps.push_back(makeStep(3, bne, 0, 0, 4'b0010, 0, 0, 1, 0, 0));
        steps.push_back(makeStep(3, nop, 0, 0, 4'b0000, 0, 0, -1, 0, 0));
        steps.push_back(makeStep(3, nop, 0, 0, 4'b0000, 0, 0, 2, 0, 0));
        testName[4] = "fullFlush";
        expectIssues[4] = 1;
        steps.push_back(makeStep(4, beq, 10, 0, 4'b0000, 0, 0, -1, 0, 0));
        steps.push_back(makeStep(4, bne, 11, 0, 4'b0000, 0, 0, -1, 0, 0));
        steps.push_back(makeStep(4, blt, 12, 0, 4'b0000, 0, 0, -1, 0, 0));
        steps.push_back(makeStep(4, bge, 13, 0, 4'b0000, 0, 0, -1, 0, 0));
        steps.push_back(makeStep(4, nop, 0, 0, 4'b0000, 0, 0, -1, 0, 0));
        steps.push_back(makeStep(4, nop, 0, 0, 4'b0000, 0, 0, -1, 1, 0));
        steps.push_back(makeStep(4, nop, 0, 0, 4'b0000, 10, 0, -1, 0, 0));
        steps.push_back(makeStep(4, jal, 0, 0, 4'b0000, 0, 0, -1, 0, 0));
        testName[5] = "freeze";
        expectIssues[5] = 2;
        steps.push_back(makeStep(5, bgeu, 0, 0, 4'b0000, 0, 0, -1, 0, 0));
        steps.push_back(makeStep(5, nop, 0, 0, 4'b0000, 0, 0, -1, 0, 1));
        steps.push_back(makeStep(5, nop, 0, 0, 4'b0000, 0, 0, -1, 0, 1));
        steps.push_back(makeStep(5, nop, 0, 0, 4'b0000, 0, 0, -1, 0, 0));
        steps.push_back(makeStep(5, jalr, 14, 0, 4'b0000, 0, 0, -1, 0, 0));
        // a broadcast while frozen must not wake the waiting slot
        steps.push_back(makeStep(5, nop, 0, 0, 4'b0000, 14, 0, -1, 0, 1));
        steps.push_back(makeStep(5, nop, 0, 0, 4'b0000, 14, 0, -1, 0, 0));
    endtask

    task automatic idleInputs();
        rdy          = 1'b1;
        aluWrEn      = 1'b0;
        aluTag       = tagFree;
        aluData      = '0;
        lsWrEn       = 1'b0;
        lsTag        = tagFree;
        lsData       = '0;
        dispEn       = 1'b0;
        dispOperandA = '0;
        dispOperandB = '0;
        dispTagA     = tagFree;
        dispTagB     = tagFree;
        dispOp       = nop;
        dispImm      = '0;
        dispPc       = '0;
        dispMask     = '0;
        bFreeEn      = 1'b0;
        bFreeNum     = '0;
        misTaken     = 1'b0;
    endtask

    task automatic applyStep(input stimStep s);
        rdy          = !s.frz;
        misTaken     = s.flush;
        dispEn       = s.op != nop;
        dispOp       = s.op;
        dispTagA     = s.tagA;
        dispTagB     = s.tagB;
        dispMask     = s.mask;
        dispOperandA = takeBits(dataWidth);
        dispOperandB = takeBits(dataWidth);
        dispImm      = takeBits(dataWidth);
        dispPc       = takeBits(addrWidth);
        aluWrEn      = s.aluTag != tagFree;
        aluTag       = s.aluTag;
        aluData      = takeBits(dataWidth);
        lsWrEn       = s.lsTag != tagFree;
        lsTag        = s.lsTag;
        lsData       = takeBits(dataWidth);
        bFreeEn      = s.freeEn;
        bFreeNum     = s.freeNum;
        @(negedge clk);
    endtask

    // wait until every expected issue has been seen, then a little longer for strays
    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        while (check_i.outstanding != 0 && waited < drainLimit) begin
            @(posedge clk);
            waited++;
        end
        repeat (2) @(posedge clk);
    endtask

    initial begin
        rst = 1'b1;
        idleInputs();
        loadTable();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int t = 0; t < numTests; t++) begin
            @(posedge clk);
            check_i.beginTest(testName[t], expectIssues[t]);
            @(negedge clk);
            foreach (steps[i]) begin
                if (steps[i].test == t) begin
                    applyStep(steps[i]);
                end
            end
            idleInputs();
            drain();
            check_i.endTest();
        end
        check_i.printTotals();
        if (check_i.failedTests == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        repeat (numTests * 40) @(posedge clk);
        $display("watchdog expired after %0d cycles without the run finishing", numTests * 40);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
